// File: hdl/fpAddPkg.sv
package fpAddPkg;

	//////////////////////////////
	// format widths
	//////////////////////////////

	localparam int expWidth  = 11;
	localparam int fracWidth = 52;
	localparam int expBias   = 1023;

	// hidden bit, fraction, then guard, round and sticky
	localparam int addWidth  = fracWidth + 4;

	//////////////////////////////
	// opcodes and operand classes
	//////////////////////////////

	typedef enum logic {
		opAdd,
		opSub
	} fpOp;

	typedef enum logic [1:0] {
		clsZero,
		clsNormal,
		clsInf,
		clsNaN
	} fpClass;

	//////////////////////////////
	// pipeline stage records
	//////////////////////////////

	typedef struct packed {
		logic                valid;
		logic                resultSign; // sign of the larger magnitude
		logic                effSub;
		logic [expWidth-1:0] bigExp;
		logic [addWidth-1:0] opA;        // larger significand
		logic [addWidth-1:0] opB;        // aligned, inverted on effSub
		fpClass              special;    // clsNormal unless special values decide
	} alignedOps;

	typedef struct packed {
		logic                valid;
		logic                resultSign;
		logic                effSub;
		logic [expWidth-1:0] bigExp;
		logic [addWidth:0]   sum;        // msb is the adder carry-out
		fpClass              special;
	} sumStage;

endpackage

// File: hdl/fpAdder.sv
module fpAdder import fpAddPkg::*; (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        inValid,
	input  fpOp                         op,
	input  logic [expWidth+fracWidth:0] a,
	input  logic [expWidth+fracWidth:0] b,
	output logic                        outValid,
	output logic [expWidth+fracWidth:0] result
);

	alignedOps         aligned; // stage 1 record
	logic [addWidth:0] sum;     // raw significand sum with carry-out

	//////////////////////////////
	// stage 1: unpack and align
	//////////////////////////////

	operandAligner u_align (
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.op      (op),
		.a       (a),
		.b       (b),
		.aligned (aligned)
	);

	//////////////////////////////
	// significand sum
	//////////////////////////////

	rippleCarryAdder u_add (
		.a   (aligned.opA),
		.b   (aligned.opB),
		.cin (aligned.effSub), // two's complement for subtraction
		.sum (sum)
	);

	//////////////////////////////
	// stages 2 and 3: round, pack
	//////////////////////////////

	resultNormalizer u_norm (
		.clk      (clk),
		.arstN    (arstN),
		.aligned  (aligned),
		.sum      (sum),
		.outValid (outValid),
		.result   (result)
	);

endmodule

// File: hdl/operandAligner.sv
module operandAligner import fpAddPkg::*; (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        inValid,
	input  fpOp                         op,
	input  logic [expWidth+fracWidth:0] a,
	input  logic [expWidth+fracWidth:0] b,
	output alignedOps                   aligned
);

	logic                          signA;
	logic                          signB;    // already flipped for opSub
	logic [expWidth-1:0]           expA;
	logic [expWidth-1:0]           expB;
	logic [fracWidth-1:0]          fracA;
	logic [fracWidth-1:0]          fracB;
	fpClass                        clsA;
	fpClass                        clsB;
	logic [expWidth+fracWidth-1:0] magA;
	logic [expWidth+fracWidth-1:0] magB;
	logic                          swap;
	logic [expWidth+fracWidth-1:0] bigMag;
	logic [expWidth+fracWidth-1:0] smallMag;
	logic                          bigSign;
	logic [expWidth-1:0]           bigExp;
	logic [expWidth-1:0]           smallExp;
	logic [expWidth-1:0]           expDiff;
	logic [addWidth-1:0]           bigSig;
	logic [addWidth-1:0]           smallSig;
	logic [addWidth-1:0]           shifted;
	logic                          sticky;
	logic [addWidth-1:0]           alignedB;
	logic                          effSub;
	alignedOps                     nextOps;

	function automatic fpClass classify(input logic [expWidth-1:0] e,
			input logic [fracWidth-1:0] f);
		if (e == '0)
			return clsZero; // subnormals are flushed here
		if (&e)
			return (f == '0) ? clsInf : clsNaN;
		return clsNormal;
	endfunction

	//////////////////////////////
	// unpack and classify
	//////////////////////////////

	assign signA = a[expWidth+fracWidth];
	assign signB = b[expWidth+fracWidth] ^ (op == opSub);
	assign expA  = a[fracWidth+:expWidth];
	assign expB  = b[fracWidth+:expWidth];
	assign fracA = a[fracWidth-1:0];
	assign fracB = b[fracWidth-1:0];
	assign clsA  = classify(expA, fracA);
	assign clsB  = classify(expB, fracB);

	// magnitudes with any subnormal fraction cleared
	assign magA = (clsA == clsZero) ? '0 : a[expWidth+fracWidth-1:0];
	assign magB = (clsB == clsZero) ? '0 : b[expWidth+fracWidth-1:0];

	//////////////////////////////
	// order by magnitude, align
	//////////////////////////////

	assign swap     = magB > magA;
	assign bigMag   = swap ? magB : magA;
	assign smallMag = swap ? magA : magB;
	assign bigSign  = swap ? signB : signA;
	assign bigExp   = bigMag[fracWidth+:expWidth];
	assign smallExp = smallMag[fracWidth+:expWidth];
	assign expDiff  = bigExp - smallExp;

	assign bigSig   = {bigExp != '0, bigMag[fracWidth-1:0], {(addWidth-fracWidth-1){1'b0}}};
	assign smallSig = {smallExp != '0, smallMag[fracWidth-1:0],
		{(addWidth-fracWidth-1){1'b0}}};

	always_comb begin
		if (expDiff >= expWidth'(addWidth)) begin
			shifted = '0;
			sticky  = |smallSig; // everything falls past the sticky bit
		end else begin
			shifted = smallSig >> expDiff;
			sticky  = |(smallSig & ~({addWidth{1'b1}} << expDiff));
		end
	end

	assign alignedB = {shifted[addWidth-1:1], shifted[0] | sticky};
	assign effSub   = signA ^ signB;

	//////////////////////////////
	// special values, stage reg
	//////////////////////////////

	always_comb begin
		nextOps.valid      = inValid;
		nextOps.resultSign = bigSign;
		nextOps.effSub     = effSub;
		nextOps.bigExp     = bigExp;
		nextOps.opA        = bigSig;
		nextOps.opB        = effSub ? ~alignedB : alignedB; // cin finishes the negate
		if (clsA == clsNaN || clsB == clsNaN)
			nextOps.special = clsNaN;
		else if (clsA == clsInf && clsB == clsInf && effSub)
			nextOps.special = clsNaN; // inf - inf
		else if (clsA == clsInf || clsB == clsInf)
			nextOps.special = clsInf;
		else if (clsA == clsZero && clsB == clsZero) begin
			nextOps.special    = clsZero;
			nextOps.resultSign = signA & signB; // -0 only for -0 + -0
		end else
			nextOps.special = clsNormal;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			aligned <= '0;
		else
			aligned <= nextOps;
	end

	// the adder relies on opA never being the smaller magnitude
	assert property (@(posedge clk) disable iff (!arstN)
		aligned.valid && aligned.special == clsNormal
		|-> aligned.opA >= (aligned.effSub ? ~aligned.opB : aligned.opB))
		else $error("aligner swap left the smaller operand in opA");

endmodule

// File: hdl/resultNormalizer.sv
module resultNormalizer import fpAddPkg::*; (
	input  logic                        clk,
	input  logic                        arstN,
	input  alignedOps                   aligned,
	input  logic [addWidth:0]           sum,
	output logic                        outValid,
	output logic [expWidth+fracWidth:0] result
);

	localparam int lzcWidth = $clog2(addWidth + 1);
	localparam logic signed [expWidth+1:0] expMax = (expWidth + 2)'(2 * expBias + 1);
	localparam logic [expWidth+fracWidth:0] quietNaN =
		{1'b0, {expWidth{1'b1}}, 1'b1, {(fracWidth-1){1'b0}}};

	sumStage                     st;
	logic [lzcWidth-1:0]         lzc;
	logic                        zeroSum;
	logic [addWidth-1:0]         norm;
	logic signed [expWidth+1:0]  baseExp;
	logic signed [expWidth+1:0]  normExp;
	logic signed [expWidth+1:0]  roundExp;
	logic                        roundUp;
	logic [fracWidth+1:0]        mantR;    // hidden bit plus carry from rounding
	logic [fracWidth-1:0]        fracR;
	logic [expWidth+fracWidth:0] packedRes;

	function automatic logic [lzcWidth-1:0] leadZeros(input logic [addWidth-1:0] v);
		logic [lzcWidth-1:0] n;
		logic                found;
		n     = '0;
		found = 1'b0;
		for (int i = addWidth - 1; i >= 0; i--) begin
			if (!found && !v[i])
				n = n + 1'b1;
			else
				found = 1'b1;
		end
		return n;
	endfunction

	//////////////////////////////
	// sum stage register
	//////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			st <= '0;
		end else begin
			st.valid      <= aligned.valid;
			st.resultSign <= aligned.resultSign;
			st.effSub     <= aligned.effSub;
			st.bigExp     <= aligned.bigExp;
			st.sum        <= sum;
			st.special    <= aligned.special;
		end
	end

	//////////////////////////////
	// normalize and round
	//////////////////////////////

	assign baseExp = {2'b00, st.bigExp};

	always_comb begin
		lzc     = leadZeros(st.sum[addWidth-1:0]);
		zeroSum = st.effSub && (st.sum[addWidth-1:0] == '0); // exact cancellation
		if (!st.effSub && st.sum[addWidth]) begin
			// carry-out moves the sum one place right and the low bits fold into sticky
			norm    = {st.sum[addWidth:2], |st.sum[1:0]};
			normExp = baseExp + (expWidth + 2)'(1);
		end else if (!st.effSub) begin
			norm    = st.sum[addWidth-1:0];
			normExp = baseExp;
		end else begin
			norm    = st.sum[addWidth-1:0] << lzc;
			normExp = baseExp - (expWidth + 2)'(lzc);
		end

		// bits 2..0 are guard, round, sticky and bit 3 is the lsb
		roundUp  = norm[2] & (norm[1] | norm[0] | norm[3]);
		mantR    = {1'b0, norm[addWidth-1:3]} + (fracWidth + 2)'(roundUp);
		fracR    = mantR[fracWidth-1:0]; // a rounding carry leaves these all zero
		roundExp = normExp + (expWidth + 2)'(mantR[fracWidth+1]);
	end

	//////////////////////////////
	// resolve and pack
	//////////////////////////////

	always_comb begin
		if (st.special == clsNaN)
			packedRes = quietNaN;
		else if (st.special == clsInf)
			packedRes = {st.resultSign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
		else if (st.special == clsZero)
			packedRes = {st.resultSign, {(expWidth+fracWidth){1'b0}}};
		else if (zeroSum)
			packedRes = '0; // x - x is +0 under nearest-even
		else if (roundExp >= expMax)
			packedRes = {st.resultSign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
		else if (roundExp[expWidth+1] || roundExp == '0)
			packedRes = {st.resultSign, {(expWidth+fracWidth){1'b0}}}; // flush to zero
		else
			packedRes = {st.resultSign, roundExp[expWidth-1:0], fracR};
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			result   <= '0;
		end else begin
			outValid <= st.valid;
			result   <= packedRes;
		end
	end

	assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid))
		else $error("outValid is unknown");

	// a finite result must leave normalization with its hidden bit in place
	assert property (@(posedge clk) disable iff (!arstN)
		st.valid && st.special == clsNormal && !zeroSum |-> norm[addWidth-1])
		else $error("normalized significand lost its hidden bit");

endmodule

// File: hdl/rippleCarryAdder.sv
module rippleCarryAdder import fpAddPkg::*; (
	input  logic [addWidth-1:0] a,
	input  logic [addWidth-1:0] b,
	input  logic                cin,
	output logic [addWidth:0]   sum
);

	logic [addWidth:0] carry; // carry[i] enters cell i

	assign carry[0] = cin;

	//////////////////////////////
	// full-adder chain
	//////////////////////////////

	genvar i;
	generate
		for (i = 0; i < addWidth; i++) begin : gCell
			logic prop;
			logic gen;

			assign prop         = a[i] ^ b[i];
			assign gen          = a[i] & b[i];
			assign sum[i]       = prop ^ carry[i];
			assign carry[i + 1] = gen | (prop & carry[i]);
		end
	endgenerate

	// carry-out, meaningful for addition only
	assign sum[addWidth] = carry[addWidth];

endmodule

// File: run.sh
#!/bin/sh
# Builds the fpAdder testbench with Verilator, runs it and checks the log.
# Run from anywhere; all paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simName=fpAdderSim

rm -rf obj_dir "$logFile"

verilator --binary --timing --assert \
	-f sources.f \
	--top-module fpAdderTb \
	-o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$logFile"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message not found in $logFile"
	exit 1
fi

// File: sources.f
hdl/fpAddPkg.sv
hdl/operandAligner.sv
hdl/rippleCarryAdder.sv
hdl/resultNormalizer.sv
hdl/fpAdder.sv
verification/fpAdderTb.sv

// File: verification/fpAdderTb.sv
module fpAdderTb import fpAddPkg::*; ();

	logic        clk;
	logic        arstN;
	logic        inValid;
	fpOp         op;
	logic [63:0] a;
	logic [63:0] b;
	logic        outValid;
	logic [63:0] result;

	logic [31:0] lfsr;
	logic [63:0] expMem [0:1023]; // expected results in send order
	logic [63:0] expHead;
	int          sentCount;
	int          outCount;
	int          valueErrors;
	int          latencyErrors;
	int          timeouts;

	fpAdder u_dut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.op       (op),
		.a        (a),
		.b        (b),
		.outValid (outValid),
		.result   (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic logic [63:0] flushSub(input logic [63:0] x);
		if (x[62:52] == 11'h000)
			return {x[63], 63'b0}; // subnormal or zero keeps only its sign
		return x;
	endfunction

	function automatic logic [63:0] expectedSum(input fpOp o, input logic [63:0] x,
			input logic [63:0] y);
		real         rx;
		real         ry;
		real         rz;
		logic [63:0] z;
		rx = $bitstoreal(flushSub(x));
		ry = $bitstoreal(flushSub(y));
		rz = (o == opSub) ? rx - ry : rx + ry; // host doubles round to nearest-even
		z  = $realtobits(rz);
		if (z[62:52] == 11'h7FF && z[51:0] != 52'h0)
			return 64'h7FF8_0000_0000_0000;
		return flushSub(z);
	endfunction

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	function automatic logic [63:0] randBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	function automatic logic [63:0] randOperand(input logic [10:0] e);
		logic [63:0] r;
		r = randBits(53);
		return {r[52], e, r[51:0]};
	endfunction

	task automatic sendOp(input fpOp o, input logic [63:0] x, input logic [63:0] y);
		@(posedge clk);
		inValid <= 1'b1;
		op      <= o;
		a       <= x;
		b       <= y;
		expMem[sentCount[9:0]] = expectedSum(o, x, y);
		sentCount++;
	endtask

	task automatic idle(input int n);
		@(posedge clk);
		inValid <= 1'b0;
		repeat (n - 1) @(posedge clk);
	endtask

	// exponents stay in a band where no result leaves the normal range
	task automatic sendRandom();
		logic [63:0] r;
		logic [10:0] eA;
		logic [10:0] eB;
		r  = randBits(8);
		eA = 11'd900 + {3'b000, r[7:0]};
		r  = randBits(7);
		eB = eA - 11'd64 + {4'b0000, r[6:0]}; // diff up to 64, past the adder width
		r  = randBits(1);
		sendOp(fpOp'(r[0]), randOperand(eA), randOperand(eB));
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (outCount != sentCount && waited < 32) begin
			@(posedge clk);
			waited++;
		end
		if (outCount != sentCount) begin
			timeouts++;
			$display("timed out: %0d results still missing after %0d cycles",
				sentCount - outCount, waited);
		end
	endtask

	//////////////////////////////
	// checking
	//////////////////////////////

	assign expHead = expMem[outCount[9:0]];

	always @(posedge clk or negedge arstN) begin
		if (!arstN)
			outCount <= 0;
		else if (outValid)
			outCount <= outCount + 1;
	end

	assert property (@(posedge clk) disable iff (!arstN) outValid |-> result === expHead)
		else begin
			valueErrors++;
			$display("Fail at time %0t: result %h for operation %0d, expected %h",
				$time, $sampled(result), $sampled(outCount), $sampled(expHead));
		end

	// exactly one result three edges after each strobe
	assert property (@(posedge clk) disable iff (!arstN) outValid == $past(inValid, 3))
		else begin
			latencyErrors++;
			$display("outValid did not follow inValid by three cycles at time %0t", $time);
		end

	assert property (@(posedge clk) !arstN |-> !outValid)
		else begin
			latencyErrors++;
			$display("outValid was high while reset was held at time %0t", $time);
		end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		logic [63:0] r;
		logic [63:0] x;
		arstN   = 1'b0;
		inValid = 1'b0;
		op      = opAdd;
		a       = '0;
		b       = '0;
		lfsr    = 32'd18;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		idle(3);

		sendOp(opAdd, 64'h3FF8_0000_0000_0000, 64'h3FF8_0000_0000_0000); // carry-out
		idle(5);
		sendOp(opAdd, 64'h3FF0_0000_0000_0000, 64'h3CA0_0000_0000_0000); // tie, stays even
		sendOp(opAdd, 64'h3FF0_0000_0000_0001, 64'h3CA0_0000_0000_0000); // tie, rounds up
		sendOp(opSub, 64'h3FF0_0000_0000_0000, 64'h3FEF_FFFF_FFFF_FFFF);
		idle(1);
		waitDrain();

		for (int i = 0; i < 200; i++) begin
			sendRandom();
			r = randBits(2);
			if (r[1:0] == 2'b00)
				idle(1);
		end
		idle(1);
		waitDrain();

		// cancellation, exact and nearly exact
		for (int i = 0; i < 8; i++) begin
			r = randBits(8);
			x = randOperand(11'd900 + {3'b000, r[7:0]});
			sendOp(opSub, x, x);
			sendOp(opAdd, x, x ^ {1'b1, 63'b0});
			sendOp(opSub, x, x ^ 64'h1);
		end
		idle(1);
		waitDrain();

		sendOp(opAdd, 64'h7FF8_0000_0000_0000, 64'h3FF0_0000_0000_0000);
		sendOp(opSub, 64'h3FF0_0000_0000_0000, 64'h7FF0_0000_0000_0001); // signaling NaN
		sendOp(opAdd, 64'hFFF8_0000_0000_0000, 64'h7FF0_0000_0000_0000);
		sendOp(opSub, 64'h7FF0_0000_0000_0000, 64'h7FF0_0000_0000_0000); // inf - inf
		sendOp(opAdd, 64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000);
		sendOp(opAdd, 64'h7FF0_0000_0000_0000, 64'h3FF0_0000_0000_0000);
		sendOp(opSub, 64'h3FF0_0000_0000_0000, 64'h7FF0_0000_0000_0000);
		sendOp(opAdd, 64'h0000_0000_0000_0000, 64'h4009_21FB_5444_2D18);
		sendOp(opAdd, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
		sendOp(opSub, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000);
		sendOp(opAdd, 64'h000F_FFFF_FFFF_FFFF, 64'h4009_21FB_5444_2D18); // subnormal input
		sendOp(opSub, 64'hC009_21FB_5444_2D18, 64'h8000_0000_0000_1234);
		idle(1);
		waitDrain();

		// overflow to signed infinity
		sendOp(opAdd, 64'h7FEF_FFFF_FFFF_FFFF, 64'h7FEF_FFFF_FFFF_FFFF);
		sendOp(opAdd, 64'hFFEF_FFFF_FFFF_FFFF, 64'hFFEF_FFFF_FFFF_FFFF);
		sendOp(opSub, 64'h7FEF_FFFF_FFFF_FFFF, 64'hFFE0_0000_0000_0000);
		idle(1);
		waitDrain();

		idle(4);
		for (int i = 0; i < 10; i++)
			sendRandom(); // back to back
		idle(1);
		waitDrain();
		idle(4);

		$display("errors: %0d wrong results, %0d latency, %0d timeouts; %0d of %0d checked",
			valueErrors, latencyErrors, timeouts, outCount, sentCount);
		if (valueErrors == 0 && latencyErrors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
